//--- hw/reorder_macros.svh
`ifndef REORDER_MACROS_SVH
`define REORDER_MACROS_SVH

// hash PE count and its log
`define NUM_HASH_PE             8
`define NUM_HASH_PE_LOG2        3

// issue lanes, also the data bytes in one beat
`define HASH_ISSUE_WIDTH        4
`define HASH_ISSUE_WIDTH_LOG2   2

// history candidates per row
`define ROW_SIZE                2
`define ADDR_WIDTH              16
`define META_MATCH_LEN_WIDTH    4

// mux fan-in per tree level, a power of two dividing the PE count
`define HASH_CROSSBAR_FACTOR    2
`define CROSSBAR_STAGE \
    ((`NUM_HASH_PE_LOG2 + $clog2(`HASH_CROSSBAR_FACTOR) - 1) / $clog2(`HASH_CROSSBAR_FACTOR))

`endif

//--- hw/reorder_pkg.sv
`default_nettype none

`include "reorder_macros.svh"

package reorder_pkg;

    // one history candidate
    typedef struct packed {
        logic                             valid;
        logic [`ADDR_WIDTH-1:0]           addr;
        logic [`META_MATCH_LEN_WIDTH-1:0] match_len;
        logic                             can_ext;
    } hist_cand_t;

    typedef hist_cand_t [`ROW_SIZE-1:0] hash_row_t;

    // what one hash PE offers in a cycle
    typedef struct packed {
        logic                   mask;
        logic [`ADDR_WIDTH-1:0] addr;
        logic                   delim;
        hash_row_t              row;
    } pe_result_t;

    typedef pe_result_t [`NUM_HASH_PE-1:0] pe_vec_t;

    // fields that ride beside the lane rows
    typedef struct packed {
        logic [`ADDR_WIDTH-1:0]          head_addr;
        logic                            delim;
        logic [`HASH_ISSUE_WIDTH*8-1:0]  data;
    } side_t;

    typedef struct packed {
        logic      row_valid;
        hash_row_t row;
    } lane_t;

    // one issue beat, lane 0 in the low bits
    typedef struct packed {
        side_t                             side;
        lane_t [`HASH_ISSUE_WIDTH-1:0]     lanes;
    } issue_beat_t;

endpackage

`default_nettype wire

//--- hw/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic arst_n,

    input  logic in_valid,
    input  T     in_data,
    output logic in_ready,

    output logic out_valid,
    output T     out_data,
    input  logic out_ready
);

    // two entries so ready can come from a register, not from out_ready
    T           mem [2];
    logic       head;
    logic       tail;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = mem[head];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= 1'b0;
            tail  <= 1'b0;
            count <= 2'd0;
        end else begin
            if (push) begin
                tail <= ~tail;
            end
            if (pop) begin
                head <= ~head;
            end
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail] <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/route_mask_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "reorder_macros.svh"

module route_mask_stage (
    input  logic                                           clk,
    input  logic                                           arst_n,

    input  logic                                           in_valid,
    input  reorder_pkg::pe_vec_t                           in_pe,
    input  logic [`HASH_ISSUE_WIDTH*8-1:0]                 in_data,
    output logic                                           in_ready,

    output logic                                           out_valid,
    output reorder_pkg::side_t                             out_side,
    output logic [`HASH_ISSUE_WIDTH-1:0][`NUM_HASH_PE-1:0] out_sel,
    output reorder_pkg::hash_row_t [`NUM_HASH_PE-1:0]      out_rows,
    input  logic                                           out_ready
);

    import reorder_pkg::*;

    typedef struct packed {
        side_t                                          side;
        logic [`HASH_ISSUE_WIDTH-1:0][`NUM_HASH_PE-1:0] sel;
        hash_row_t [`NUM_HASH_PE-1:0]                   rows;
    } mask_beat_t;

    mask_beat_t d;
    mask_beat_t q;

    always_comb begin
        d           = '0;
        d.side.data = in_data;
        for (int i = 0; i < `NUM_HASH_PE; i++) begin
            d.rows[i] = in_pe[i].row;
            if (in_pe[i].mask) begin
                d.side.head_addr = d.side.head_addr | in_pe[i].addr;
                // delimiter only counts from active PEs
                d.side.delim     = d.side.delim | in_pe[i].delim;
            end
            // lane chosen by the low address bits
            for (int j = 0; j < `HASH_ISSUE_WIDTH; j++) begin
                d.sel[j][i] = in_pe[i].mask &&
                    (in_pe[i].addr[`HASH_ISSUE_WIDTH_LOG2-1:0] == `HASH_ISSUE_WIDTH_LOG2'(j));
            end
        end
        // head is aligned to the issue width
        d.side.head_addr[`HASH_ISSUE_WIDTH_LOG2-1:0] = '0;
    end

    pipe_reg #(.T(mask_beat_t)) u_stage_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_data   (d),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (q),
        .out_ready (out_ready)
    );

    assign out_side = q.side;
    assign out_sel  = q.sel;
    assign out_rows = q.rows;

endmodule

`default_nettype wire

//--- hw/lane_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "reorder_macros.svh"

module lane_crossbar (
    input  logic                                           clk,
    input  logic                                           arst_n,

    input  logic                                           in_valid,
    input  reorder_pkg::side_t                             in_side,
    input  logic [`HASH_ISSUE_WIDTH-1:0][`NUM_HASH_PE-1:0] in_sel,
    input  reorder_pkg::hash_row_t [`NUM_HASH_PE-1:0]      in_rows,
    output logic                                           in_ready,

    output logic                                           out_valid,
    output reorder_pkg::issue_beat_t                       out_beat,
    input  logic                                           out_ready
);

    import reorder_pkg::*;

    localparam int NPE    = `NUM_HASH_PE;
    localparam int HIW    = `HASH_ISSUE_WIDTH;
    localparam int F      = `HASH_CROSSBAR_FACTOR;
    localparam int FL     = $clog2(`HASH_CROSSBAR_FACTOR);
    localparam int STAGES = `CROSSBAR_STAGE;
    localparam int ROW_W  = $bits(hash_row_t);

    // level boundaries, sized for the widest level and zero filled above
    logic                          lvl_valid [STAGES+1];
    logic                          lvl_ready [STAGES+1];
    side_t                         lvl_side  [STAGES+1];
    logic [HIW-1:0][NPE-1:0]       lvl_sel   [STAGES+1];
    hash_row_t [HIW-1:0][NPE-1:0]  lvl_rows  [STAGES+1];

    assign lvl_valid[0] = in_valid;
    assign in_ready     = lvl_ready[0];
    assign lvl_side[0]  = in_side;
    assign lvl_sel[0]   = in_sel;

    // every lane starts from the full set of PE rows
    for (genvar j = 0; j < HIW; j++) begin : g_lane_in
        assign lvl_rows[0][j] = in_rows;
    end

    for (genvar i = 0; i < STAGES; i++) begin : g_level
        localparam int IN_NUM  = NPE >> (i * FL);
        localparam int OUT_NUM = (IN_NUM > F) ? (IN_NUM / F) : 1;
        localparam int FACTOR  = IN_NUM / OUT_NUM;

        typedef struct packed {
            side_t                             side;
            logic [HIW-1:0][OUT_NUM-1:0]       sel;
            hash_row_t [HIW-1:0][OUT_NUM-1:0]  rows;
        } level_t;

        level_t d;
        level_t q;

        // one-hot and-or over each group, all lanes at once
        always_comb begin
            d.side = lvl_side[i];
            d.sel  = '0;
            d.rows = '0;
            for (int j = 0; j < HIW; j++) begin
                for (int k = 0; k < OUT_NUM; k++) begin
                    d.sel[j][k] = |lvl_sel[i][j][k*FACTOR +: FACTOR];
                    for (int m = 0; m < FACTOR; m++) begin
                        d.rows[j][k] = d.rows[j][k] | (lvl_rows[i][j][k*FACTOR+m] &
                            {ROW_W{lvl_sel[i][j][k*FACTOR+m]}});
                    end
                end
            end
        end

        pipe_reg #(.T(level_t)) u_level_reg (
            .clk       (clk),
            .arst_n    (arst_n),
            .in_valid  (lvl_valid[i]),
            .in_data   (d),
            .in_ready  (lvl_ready[i]),
            .out_valid (lvl_valid[i+1]),
            .out_data  (q),
            .out_ready (lvl_ready[i+1])
        );

        assign lvl_side[i+1] = q.side;
        for (genvar j = 0; j < HIW; j++) begin : g_lane_out
            assign lvl_sel[i+1][j]  = NPE'(q.sel[j]);
            assign lvl_rows[i+1][j] = (NPE*ROW_W)'(q.rows[j]);
        end
    end

    assign out_valid         = lvl_valid[STAGES];
    assign lvl_ready[STAGES] = out_ready;
    assign out_beat.side     = lvl_side[STAGES];

    // a single entry per lane is left after the last level
    for (genvar j = 0; j < HIW; j++) begin : g_lane_beat
        assign out_beat.lanes[j].row_valid = lvl_sel[STAGES][j][0];
        assign out_beat.lanes[j].row       = lvl_rows[STAGES][j][0];
    end

endmodule

`default_nettype wire

//--- hw/reorder_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "reorder_macros.svh"

module reorder_crossbar (
    input  logic                            clk,
    input  logic                            arst_n,

    input  logic                            in_valid,
    input  reorder_pkg::pe_vec_t            in_pe,
    input  logic [`HASH_ISSUE_WIDTH*8-1:0]  in_data,
    output logic                            in_ready,

    output logic                            out_valid,
    output reorder_pkg::issue_beat_t        out_beat,
    input  logic                            out_ready
);

    import reorder_pkg::*;

    // mask stage to crossbar
    logic                                           mask_valid;
    logic                                           mask_ready;
    side_t                                          mask_side;
    logic [`HASH_ISSUE_WIDTH-1:0][`NUM_HASH_PE-1:0] mask_sel;
    hash_row_t [`NUM_HASH_PE-1:0]                   mask_rows;

    // crossbar to output register
    logic                                           xbar_valid;
    logic                                           xbar_ready;
    issue_beat_t                                    xbar_beat;

    route_mask_stage u_mask (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_pe     (in_pe),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (mask_valid),
        .out_side  (mask_side),
        .out_sel   (mask_sel),
        .out_rows  (mask_rows),
        .out_ready (mask_ready)
    );

    lane_crossbar u_xbar (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (mask_valid),
        .in_side   (mask_side),
        .in_sel    (mask_sel),
        .in_rows   (mask_rows),
        .in_ready  (mask_ready),
        .out_valid (xbar_valid),
        .out_beat  (xbar_beat),
        .out_ready (xbar_ready)
    );

    pipe_reg #(.T(issue_beat_t)) u_out_reg (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (xbar_valid),
        .in_data   (xbar_beat),
        .in_ready  (xbar_ready),
        .out_valid (out_valid),
        .out_data  (out_beat),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

//--- testbench/tb_reorder_crossbar_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_reorder_crossbar_assert (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     in_valid,
    input logic                     in_ready,
    input logic                     out_valid,
    input reorder_pkg::issue_beat_t out_beat,
    input logic                     out_ready
);

    int unsigned fail_count = 0;
    logic [7:0]  in_flight;

    // beats accepted but not yet delivered
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + 8'(in_valid && in_ready) - 8'(out_valid && out_ready);
        end
    end

    // a beat entering an empty pipe leaves after five cycles
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        (in_valid && in_ready && in_flight == 8'd0 && out_ready)
            |=> (!out_valid)[*4] ##1 out_valid)
        else begin
            $error("out_valid did not rise five cycles after an isolated input beat");
            fail_count++;
        end

    // stalled output holds valid and payload
    a_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else begin
            $error("output beat changed or dropped while stalled");
            fail_count++;
        end

    a_reset_valid: assert property (@(posedge clk) !arst_n |-> !out_valid)
        else begin
            $error("out_valid high during reset");
            fail_count++;
        end

    a_reset_ready: assert property (@(posedge clk) $rose(arst_n) |-> in_ready)
        else begin
            $error("in_ready low right after reset");
            fail_count++;
        end

endmodule

bind reorder_crossbar tb_reorder_crossbar_assert u_assert (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
);

`default_nettype wire

//--- testbench/tb_reorder_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "reorder_macros.svh"

module tb_reorder_crossbar;

    import reorder_pkg::*;

    localparam int NUM_RANDOM = 200;
    localparam int TIMEOUT    = 200;
    localparam int DATA_W     = `HASH_ISSUE_WIDTH * 8;

    logic              clk;
    logic              arst_n;
    logic              in_valid;
    pe_vec_t           in_pe;
    logic [DATA_W-1:0] in_data;
    logic              in_ready;
    logic              out_valid;
    issue_beat_t       out_beat;
    logic              out_ready;

    logic [31:0]       rng;
    logic              stall_en;
    issue_beat_t       exp_q[$];

    reorder_crossbar UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_pe     (in_pe),
        .in_data   (in_data),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_beat  (out_beat),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic pe_vec_t random_pe_vec();
        pe_vec_t     v;
        logic [31:0] r;
        for (int i = 0; i < `NUM_HASH_PE; i++) begin
            r          = rand_word();
            v[i].mask  = (r[3:0] < 4'd10);
            v[i].delim = (r[7:4] == 4'd0);
            v[i].addr  = r[31:16];
            for (int c = 0; c < `ROW_SIZE; c++) begin
                r                     = rand_word();
                v[i].row[c].valid     = r[0];
                v[i].row[c].can_ext   = r[1];
                v[i].row[c].match_len = r[8 +: `META_MATCH_LEN_WIDTH];
                v[i].row[c].addr      = r[31:16];
            end
        end
        return v;
    endfunction

    // kind 0 one PE per lane, kind 1 two per lane, else nothing masked
    function automatic pe_vec_t directed_pe_vec(input int kind);
        pe_vec_t v;
        v = random_pe_vec();
        for (int i = 0; i < `NUM_HASH_PE; i++) begin
            v[i].mask = (kind == 0) ? (i < `HASH_ISSUE_WIDTH) : (kind == 1);
            v[i].addr[`HASH_ISSUE_WIDTH_LOG2-1:0] = `HASH_ISSUE_WIDTH_LOG2'(i);
        end
        return v;
    endfunction

    // lane rows are the OR over every masked PE aimed at the lane
    function automatic issue_beat_t expected_beat(input pe_vec_t pe,
                                                  input logic [DATA_W-1:0] data);
        issue_beat_t                       b;
        logic [`HASH_ISSUE_WIDTH_LOG2-1:0] lane;
        b           = '0;
        b.side.data = data;
        for (int i = 0; i < `NUM_HASH_PE; i++) begin
            if (pe[i].mask) begin
                lane                    = pe[i].addr[`HASH_ISSUE_WIDTH_LOG2-1:0];
                b.side.head_addr        = b.side.head_addr | pe[i].addr;
                b.side.delim            = b.side.delim | pe[i].delim;
                b.lanes[lane].row_valid = 1'b1;
                b.lanes[lane].row       = b.lanes[lane].row | pe[i].row;
            end
        end
        b.side.head_addr[`HASH_ISSUE_WIDTH_LOG2-1:0] = '0;
        return b;
    endfunction

    task automatic fail_run();
        $display("Done: errors found");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("[ERROR] %s: got %0h, expected %0h", name, got, exp);
        fail_run();
    endtask

    task automatic check_beat(input issue_beat_t got, input issue_beat_t exp);
        assert (got.side.head_addr == exp.side.head_addr)
            else value_error("out_beat.side.head_addr", got.side.head_addr, exp.side.head_addr);
        assert (got.side.delim == exp.side.delim)
            else value_error("out_beat.side.delim", got.side.delim, exp.side.delim);
        assert (got.side.data == exp.side.data)
            else value_error("out_beat.side.data", got.side.data, exp.side.data);
        for (int j = 0; j < `HASH_ISSUE_WIDTH; j++) begin
            assert (got.lanes[j].row_valid == exp.lanes[j].row_valid)
                else value_error($sformatf("out_beat.lanes[%0d].row_valid", j),
                                 got.lanes[j].row_valid, exp.lanes[j].row_valid);
            assert (got.lanes[j].row == exp.lanes[j].row)
                else value_error($sformatf("out_beat.lanes[%0d].row", j),
                                 got.lanes[j].row, exp.lanes[j].row);
        end
    endtask

    // one clock, record a transfer, then drive out_ready
    task automatic next_cycle(output logic took);
        @(posedge clk);
        took = in_valid && in_ready;
        if (took) begin
            exp_q.push_back(expected_beat(in_pe, in_data));
        end
        #2;
        out_ready = stall_en ? (rand_word() % 4 != 0) : 1'b1;
    endtask

    task automatic send_beat(input pe_vec_t pe, input logic [DATA_W-1:0] data, input int gap);
        logic took;
        int   waited;
        in_valid = 1'b0;
        repeat (gap) next_cycle(took);
        in_valid = 1'b1;
        in_pe    = pe;
        in_data  = data;
        waited   = 0;
        took     = 1'b0;
        while (!took) begin
            next_cycle(took);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timed out waiting for in_ready");
                fail_run();
            end
        end
    endtask

    task automatic drain();
        logic took;
        int   waited;
        in_valid = 1'b0;
        waited   = 0;
        while (exp_q.size() != 0) begin
            next_cycle(took);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timed out waiting for expected beats to leave the DUT");
                fail_run();
            end
        end
    endtask

    // compare every output transfer with the oldest expected beat
    always @(posedge clk) begin
        issue_beat_t exp;
        if (arst_n && out_valid && out_ready) begin
            assert (exp_q.size() > 0) else begin
                $display("output beat arrived while no beat was expected");
                fail_run();
            end
            if (exp_q.size() > 0) begin
                exp = exp_q.pop_front();
                check_beat(out_beat, exp);
            end
        end
    end

    always @(posedge clk) begin
        if (UUT.u_assert.fail_count != 0) begin
            $display("a bound protocol assertion failed");
            fail_run();
        end
    end

    initial begin
        pe_vec_t           pe;
        logic [DATA_W-1:0] data;
        int                gap;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        in_pe     = '0;
        in_data   = '0;
        out_ready = 1'b1;
        stall_en  = 1'b0;
        rng       = 32'h8a72;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // isolated beat into an empty pipe
        pe   = random_pe_vec();
        data = DATA_W'(rand_word());
        send_beat(pe, data, 1);
        drain();

        for (int k = 0; k < 3; k++) begin
            pe   = directed_pe_vec(k);
            data = DATA_W'(rand_word());
            send_beat(pe, data, 0);
        end
        drain();

        // random traffic with gaps and output stalls
        stall_en = 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            gap  = (rand_word() % 4 == 0) ? 1 + int'(rand_word() % 2) : 0;
            pe   = random_pe_vec();
            data = DATA_W'(rand_word());
            send_beat(pe, data, gap);
        end
        stall_en = 1'b0;
        drain();

        if (UUT.u_assert.fail_count == 0 && exp_q.size() == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+hw
hw/reorder_pkg.sv
hw/pipe_reg.sv
hw/route_mask_stage.sv
hw/lane_crossbar.sv
hw/reorder_crossbar.sv
testbench/tb_reorder_crossbar_assert.sv
testbench/tb_reorder_crossbar.sv
